// ==== verilog.f ====
+incdir+include
logic/csr_pkg.sv
logic/mmu_pkg.sv
logic/mmu_if.sv
logic/mmu_csr.sv
logic/tlb_array.sv
logic/xlat_port.sv
logic/mmu_top.sv
sim/tb_mmu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the mmu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_mmu -f verilog.f -o Vtb_mmu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_mmu > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== include/tb_mmu_tasks.svh ====
`ifndef TB_MMU_TASKS_SVH
`define TB_MMU_TASKS_SVH

// field packing of the translation csrs
function automatic logic [31:0] crmd_word(input logic [1:0] plv, input logic da,
	input logic pg, input logic [1:0] datf, input logic [1:0] datm);
	return {23'b0, datm, datf, pg, da, 1'b0, plv};
endfunction

function automatic logic [31:0] dmw_word(input logic [2:0] vseg, input logic [2:0] pseg,
	input logic [1:0] mat, input logic plv3, input logic plv0);
	return {vseg, 1'b0, pseg, 19'b0, mat, plv3, 2'b0, plv0};
endfunction

function automatic logic [31:0] elo_word(input logic [19:0] ppn, input logic g,
	input logic [1:0] mat, input logic [1:0] plv, input logic d, input logic v);
	return {4'b0, ppn, 1'b0, g, mat, plv, d, v};
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
	if (got !== expected) begin
		$display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, got, expected);
		$display("RESULT: FAIL");
		$fatal(1, "mismatch on %s", name);
	end
endtask

// called on a falling edge, returns on the next one
task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
	csr_we_i    = 1'b1;
	csr_addr_i  = addr;
	csr_wdata_i = data;
	@(negedge clk);
	csr_we_i = 1'b0;
endtask

task automatic tlb_fill(input logic [2:0] idx, input logic [18:0] vppn,
	input logic [9:0] asid, input logic [31:0] lo0, input logic [31:0] lo1);
	csr_write(CSR_ASID, {22'b0, asid});
	csr_write(CSR_TLBEHI, {vppn, 13'b0});
	csr_write(CSR_TLBELO0, lo0);
	csr_write(CSR_TLBELO1, lo1);
	csr_write(CSR_TLBIDX, {29'b0, idx});
	tlbwr_i = 1'b1;
	@(negedge clk);
	tlbwr_i = 1'b0;
	// entry lands two edges after the strobe
	@(negedge clk);
endtask

task automatic compare_fetch_resp(input logic [31:0] paddr, input logic [1:0] mat,
	input xlat_exc_t exc);
	check("i_resp_valid_o", 32'(i_resp_valid_o), 32'd1);
	check("i_exc_o", 32'(i_exc_o), 32'(exc));
	check("i_paddr_o", i_paddr_o, paddr);
	check("i_mat_o", 32'(i_mat_o), 32'(mat));
	check("i_uncached_o", 32'(i_uncached_o), 32'(mat == MAT_SUC));
endtask

task automatic compare_data_resp(input logic [31:0] paddr, input logic [1:0] mat,
	input xlat_exc_t exc);
	check("d_resp_valid_o", 32'(d_resp_valid_o), 32'd1);
	check("d_exc_o", 32'(d_exc_o), 32'(exc));
	check("d_paddr_o", d_paddr_o, paddr);
	check("d_mat_o", 32'(d_mat_o), 32'(mat));
	check("d_uncached_o", 32'(d_uncached_o), 32'(mat == MAT_SUC));
endtask

// address and valid go out together, result checked one cycle later
task automatic translate_i(input logic [31:0] vaddr, input logic [31:0] paddr,
	input logic [1:0] mat, input xlat_exc_t exc);
	i_vaddr_i     = vaddr;
	i_req_valid_i = 1'b1;
	@(negedge clk);
	i_req_valid_i = 1'b0;
	compare_fetch_resp(paddr, mat, exc);
endtask

task automatic translate_d(input logic [31:0] vaddr, input logic store,
	input logic [31:0] paddr, input logic [1:0] mat, input xlat_exc_t exc);
	d_vaddr_i     = vaddr;
	d_store_i     = store;
	d_req_valid_i = 1'b1;
	@(negedge clk);
	d_req_valid_i = 1'b0;
	compare_data_resp(paddr, mat, exc);
endtask

`endif

// ==== sim/tb_mmu.sv ====
`timescale 1ns/10ps

module tb_mmu import csr_pkg::*, mmu_pkg::*; ();

	// far above the length of the whole sequence
	localparam int MAX_CYCLES = 2000;

	// tlb pages, all outside both windows
	localparam logic [18:0] VPPN_A = 19'h0_2345;
	localparam logic [18:0] VPPN_G = 19'h0_4000;
	localparam logic [18:0] VPPN_X = 19'h0_6000;
	localparam logic [18:0] VPPN_Y = 19'h0_6002;
	localparam logic [19:0] PPN_A0 = 20'h0_0abc;
	localparam logic [19:0] PPN_A1 = 20'h0_0abd;
	localparam logic [19:0] PPN_G0 = 20'h3_3000;
	localparam logic [19:0] PPN_G1 = 20'h3_3001;
	localparam logic [19:0] PPN_X1 = 20'h5_0001;
	localparam logic [19:0] PPN_Y0 = 20'h6_0000;
	localparam logic [19:0] PPN_Y1 = 20'h6_0001;

	logic        clk;
	logic        rst_n_i;
	logic        csr_we_i;
	logic [13:0] csr_addr_i;
	logic [31:0] csr_wdata_i;
	logic        tlbwr_i;
	logic        i_req_valid_i;
	logic [31:0] i_vaddr_i;
	logic        d_req_valid_i;
	logic [31:0] d_vaddr_i;
	logic        d_store_i;
	logic        i_resp_valid_o;
	logic [31:0] i_paddr_o;
	logic [1:0]  i_mat_o;
	logic        i_uncached_o;
	logic [2:0]  i_exc_o;
	logic        d_resp_valid_o;
	logic [31:0] d_paddr_o;
	logic [1:0]  d_mat_o;
	logic        d_uncached_o;
	logic [2:0]  d_exc_o;
	integer      seed;
	int          cycles = 0;

	mmu_top i_dut (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.csr_we_i       (csr_we_i),
		.csr_addr_i     (csr_addr_i),
		.csr_wdata_i    (csr_wdata_i),
		.tlbwr_i        (tlbwr_i),
		.i_req_valid_i  (i_req_valid_i),
		.i_vaddr_i      (i_vaddr_i),
		.d_req_valid_i  (d_req_valid_i),
		.d_vaddr_i      (d_vaddr_i),
		.d_store_i      (d_store_i),
		.i_resp_valid_o (i_resp_valid_o),
		.i_paddr_o      (i_paddr_o),
		.i_mat_o        (i_mat_o),
		.i_uncached_o   (i_uncached_o),
		.i_exc_o        (i_exc_o),
		.d_resp_valid_o (d_resp_valid_o),
		.d_paddr_o      (d_paddr_o),
		.d_mat_o        (d_mat_o),
		.d_uncached_o   (d_uncached_o),
		.d_exc_o        (d_exc_o)
	);

	`include "tb_mmu_tasks.svh"

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic test_direct();
		logic [31:0] va;
		check("i_resp_valid_o", 32'(i_resp_valid_o), 32'd0);
		check("d_resp_valid_o", 32'(d_resp_valid_o), 32'd0);
		for (int k = 0; k < 2; k++) begin
			csr_write(CSR_CRMD, crmd_word(2'd0, 1'b1, 1'b0, 2'(1 - k), 2'(k)));
			repeat (4) begin
				va = $random(seed);
				translate_i(va, va, 2'(1 - k), EXC_NONE);
				va = $random(seed);
				translate_d(va, 1'b0, va, 2'(k), EXC_NONE);
			end
		end
	endtask

	task automatic test_dmw();
		logic [31:0] rnd;
		csr_write(CSR_DMW0, dmw_word(3'h5, 3'h1, 2'b01, 1'b0, 1'b1));
		csr_write(CSR_DMW1, dmw_word(3'h4, 3'h2, 2'b00, 1'b0, 1'b1));
		csr_write(CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 2'b00, 2'b00));
		rnd = $random(seed);
		translate_i({3'h5, rnd[28:0]}, {3'h1, rnd[28:0]}, 2'b01, EXC_NONE);
		translate_d({3'h4, rnd[28:0]}, 1'b0, {3'h2, rnd[28:0]}, 2'b00, EXC_NONE);
		// overlapping windows
		csr_write(CSR_DMW1, dmw_word(3'h5, 3'h2, 2'b00, 1'b0, 1'b1));
		translate_d({3'h5, rnd[28:0]}, 1'b1, {3'h1, rnd[28:0]}, 2'b01, EXC_NONE);
		csr_write(CSR_CRMD, crmd_word(2'd3, 1'b0, 1'b1, 2'b00, 2'b00));
		translate_i({3'h5, rnd[28:0]}, 32'h0, 2'b00, EXC_TLBR);
		csr_write(CSR_DMW1, dmw_word(3'h4, 3'h2, 2'b00, 1'b0, 1'b1));
		csr_write(CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 2'b00, 2'b00));
	endtask

	task automatic test_tlb();
		tlb_fill(3'd0, VPPN_A, 10'h011, elo_word(PPN_A0, 1'b0, 2'b01, 2'd0, 1'b1, 1'b1),
			elo_word(PPN_A1, 1'b0, 2'b00, 2'd0, 1'b1, 1'b1));
		tlb_fill(3'd1, VPPN_G, 10'h011, elo_word(PPN_G0, 1'b1, 2'b01, 2'd0, 1'b1, 1'b1),
			elo_word(PPN_G1, 1'b1, 2'b11, 2'd0, 1'b1, 1'b1));
		translate_i({VPPN_A, 13'h0123}, {PPN_A0, 12'h123}, 2'b01, EXC_NONE);
		translate_d({VPPN_A, 13'h1456}, 1'b0, {PPN_A1, 12'h456}, 2'b00, EXC_NONE);
		csr_write(CSR_ASID, 32'h022);
		translate_i({VPPN_G, 13'h1789}, {PPN_G1, 12'h789}, 2'b11, EXC_NONE);
		translate_d({VPPN_A, 13'h0123}, 1'b0, 32'h0, 2'b00, EXC_TLBR);
	endtask

	task automatic test_exc();
		// even half invalid, odd half clean
		tlb_fill(3'd2, VPPN_X, 10'h022, elo_word(20'h0, 1'b0, 2'b01, 2'd0, 1'b1, 1'b0),
			elo_word(PPN_X1, 1'b0, 2'b01, 2'd0, 1'b0, 1'b1));
		tlb_fill(3'd3, VPPN_Y, 10'h022, elo_word(PPN_Y0, 1'b0, 2'b01, 2'd0, 1'b1, 1'b1),
			elo_word(PPN_Y1, 1'b0, 2'b01, 2'd3, 1'b1, 1'b1));
		translate_i({VPPN_X, 13'h0010}, 32'h0, 2'b00, EXC_PIF);
		translate_d({VPPN_X, 13'h0010}, 1'b0, 32'h0, 2'b00, EXC_PIL);
		translate_d({VPPN_X, 13'h0010}, 1'b1, 32'h0, 2'b00, EXC_PIS);
		translate_d({VPPN_X, 13'h1020}, 1'b1, 32'h0, 2'b00, EXC_PME);
		translate_d({VPPN_X, 13'h1020}, 1'b0, {PPN_X1, 12'h020}, 2'b01, EXC_NONE);
		csr_write(CSR_CRMD, crmd_word(2'd3, 1'b0, 1'b1, 2'b00, 2'b00));
		translate_d({VPPN_Y, 13'h0abc}, 1'b0, 32'h0, 2'b00, EXC_PPI);
		translate_i({VPPN_Y, 13'h1abc}, {PPN_Y1, 12'habc}, 2'b01, EXC_NONE);
		csr_write(CSR_CRMD, crmd_word(2'd0, 1'b0, 1'b1, 2'b00, 2'b00));
	endtask

	task automatic test_pipeline();
		logic [31:0] rnd;
		logic [31:0] pi;
		logic [31:0] pd;
		logic [1:0]  mi;
		logic [1:0]  md;
		xlat_exc_t   ei;
		xlat_exc_t   ed;
		for (int n = 0; n <= 16; n++) begin
			if (n > 0) begin
				compare_fetch_resp(pi, mi, ei);
				compare_data_resp(pd, md, ed);
			end
			i_req_valid_i = (n < 16);
			d_req_valid_i = (n < 16);
			rnd = $random(seed);
			ei  = EXC_NONE;
			ed  = EXC_NONE;
			d_store_i = n[1];
			if (n[0] == 1'b0) begin
				i_vaddr_i = {3'h5, rnd[28:0]};
				pi = {3'h1, rnd[28:0]};
				mi = 2'b01;
				d_vaddr_i = {3'h4, rnd[31:3]};
				pd = {3'h2, rnd[31:3]};
				md = 2'b00;
			end else begin
				i_vaddr_i = {VPPN_G, rnd[12:0]};
				pi = {rnd[12] ? PPN_G1 : PPN_G0, rnd[11:0]};
				mi = rnd[12] ? 2'b11 : 2'b01;
				d_vaddr_i = {VPPN_X, 1'b1, rnd[27:16]};
				pd = n[1] ? 32'h0 : {PPN_X1, rnd[27:16]};
				md = n[1] ? 2'b00 : 2'b01;
				ed = n[1] ? EXC_PME : EXC_NONE;
			end
			@(negedge clk);
		end
	endtask

	initial begin
		seed          = 32'h5dba;
		rst_n_i       = 1'b0;
		csr_we_i      = 1'b0;
		csr_addr_i    = '0;
		csr_wdata_i   = '0;
		tlbwr_i       = 1'b0;
		i_req_valid_i = 1'b0;
		i_vaddr_i     = '0;
		d_req_valid_i = 1'b0;
		d_vaddr_i     = '0;
		d_store_i     = 1'b0;
		repeat (5) @(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		test_direct();
		test_dmw();
		test_tlb();
		test_exc();
		test_pipeline();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== logic/mmu_top.sv ====
`timescale 1ns/10ps

module mmu_top import mmu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,

	input  logic        csr_we_i,
	input  logic [13:0] csr_addr_i,
	input  logic [31:0] csr_wdata_i,
	input  logic        tlbwr_i,

	input  logic        i_req_valid_i,
	input  logic [31:0] i_vaddr_i,

	input  logic        d_req_valid_i,
	input  logic [31:0] d_vaddr_i,
	input  logic        d_store_i,

	output logic        i_resp_valid_o,
	output logic [31:0] i_paddr_o,
	output logic [1:0]  i_mat_o,
	output logic        i_uncached_o,
	output logic [2:0]  i_exc_o,

	output logic        d_resp_valid_o,
	output logic [31:0] d_paddr_o,
	output logic [1:0]  d_mat_o,
	output logic        d_uncached_o,
	output logic [2:0]  d_exc_o
);

	logic                 tlb_we;
	logic [TLB_IDX_W-1:0] tlb_widx;
	tlb_entry_t           tlb_wentry;
	acc_kind_t            d_kind;

	csr_view_if   csr_view ();
	tlb_lookup_if i_lookup ();
	tlb_lookup_if d_lookup ();

	assign d_kind = d_store_i ? ACC_STORE : ACC_LOAD;

	mmu_csr u_csr (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.csr_we_i     (csr_we_i),
		.csr_addr_i   (csr_addr_i),
		.csr_wdata_i  (csr_wdata_i),
		.tlbwr_i      (tlbwr_i),
		.view_o       (csr_view),
		.tlb_we_o     (tlb_we),
		.tlb_widx_o   (tlb_widx),
		.tlb_wentry_o (tlb_wentry)
	);

	tlb_array u_tlb (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.we_i     (tlb_we),
		.widx_i   (tlb_widx),
		.wentry_i (tlb_wentry),
		.lk_i     (i_lookup),
		.lk_d     (d_lookup)
	);

	// fetch side
	xlat_port u_ifetch (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (i_req_valid_i),
		.vaddr_i      (i_vaddr_i),
		.kind_i       (ACC_FETCH),
		.csr_i        (csr_view),
		.tlb_o        (i_lookup),
		.resp_valid_o (i_resp_valid_o),
		.paddr_o      (i_paddr_o),
		.mat_o        (i_mat_o),
		.uncached_o   (i_uncached_o),
		.exc_o        (i_exc_o)
	);

	// load/store side
	xlat_port u_data (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (d_req_valid_i),
		.vaddr_i      (d_vaddr_i),
		.kind_i       (d_kind),
		.csr_i        (csr_view),
		.tlb_o        (d_lookup),
		.resp_valid_o (d_resp_valid_o),
		.paddr_o      (d_paddr_o),
		.mat_o        (d_mat_o),
		.uncached_o   (d_uncached_o),
		.exc_o        (d_exc_o)
	);

endmodule

// ==== logic/xlat_port.sv ====
`timescale 1ns/10ps

module xlat_port import csr_pkg::*, mmu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        req_valid_i,
	input  logic [31:0] vaddr_i,
	input  acc_kind_t   kind_i,
	csr_view_if.user    csr_i,
	tlb_lookup_if.requester tlb_o,
	output logic        resp_valid_o,
	output logic [31:0] paddr_o,
	output logic [1:0]  mat_o,
	output logic        uncached_o,
	output xlat_exc_t   exc_o
);

	logic        dmw0_hit;
	logic        dmw1_hit;
	logic [31:0] paddr_d;
	logic [1:0]  mat_d;
	xlat_exc_t   exc_d;

	function automatic logic dmw_match(
		input dmw_t       w,
		input logic [1:0] plv,
		input logic [2:0] seg
	);
		return ((w.plv0 && plv == 2'd0) || (w.plv3 && plv == 2'd3)) && (seg == w.vseg);
	endfunction

	assign tlb_o.vppn = vaddr_i[31:13];
	assign tlb_o.odd  = vaddr_i[12];
	assign tlb_o.asid = csr_i.asid;

	assign dmw0_hit = csr_i.crmd.pg && dmw_match(csr_i.dmw0, csr_i.crmd.plv, vaddr_i[31:29]);
	assign dmw1_hit = csr_i.crmd.pg && dmw_match(csr_i.dmw1, csr_i.crmd.plv, vaddr_i[31:29]);

	always_comb begin
		paddr_d = '0;
		mat_d   = '0;
		exc_d   = EXC_NONE;
		if (csr_i.crmd.da) begin
			paddr_d = vaddr_i;
			mat_d   = (kind_i == ACC_FETCH) ? csr_i.crmd.datf : csr_i.crmd.datm;
		end else if (dmw0_hit) begin
			paddr_d = {csr_i.dmw0.pseg, vaddr_i[28:0]};
			mat_d   = csr_i.dmw0.mat;
		end else if (dmw1_hit) begin
			paddr_d = {csr_i.dmw1.pseg, vaddr_i[28:0]};
			mat_d   = csr_i.dmw1.mat;
		end else if (!tlb_o.hit) begin
			exc_d = EXC_TLBR;
		end else if (!tlb_o.page.v) begin
			case (kind_i)
				ACC_FETCH: exc_d = EXC_PIF;
				ACC_STORE: exc_d = EXC_PIS;
				default:   exc_d = EXC_PIL;
			endcase
		end else if (csr_i.crmd.plv > tlb_o.page.plv) begin
			exc_d = EXC_PPI;
		end else if (kind_i == ACC_STORE && !tlb_o.page.d) begin
			exc_d = EXC_PME;
		end else begin
			paddr_d = {tlb_o.page.ppn, vaddr_i[11:0]};
			mat_d   = tlb_o.page.mat;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			resp_valid_o <= 1'b0;
		end else begin
			resp_valid_o <= req_valid_i;
		end
	end

	// result holds until the next request
	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			paddr_o    <= paddr_d;
			mat_o      <= mat_d;
			uncached_o <= (mat_d == MAT_SUC);
			exc_o      <= exc_d;
		end
	end

	a_da_identity: assert property (@(posedge clk) disable iff (!rst_n_i)
		resp_valid_o && exc_o == EXC_NONE && $past(csr_i.crmd.da)
		|-> paddr_o == $past(vaddr_i));

endmodule

// ==== logic/tlb_array.sv ====
`timescale 1ns/10ps

module tlb_array import mmu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 we_i,
	input  logic [TLB_IDX_W-1:0] widx_i,
	input  tlb_entry_t           wentry_i,
	tlb_lookup_if.responder      lk_i,
	tlb_lookup_if.responder      lk_d
);

	logic [TLB_ENTRIES-1:0] e_q;
	tlb_entry_t             ent_q [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0] hits_if;
	logic [TLB_ENTRIES-1:0] hits_dt;

	// parallel compare against every entry
	function automatic logic [TLB_ENTRIES-1:0] match_vec(
		input logic [VPPN_W-1:0] vppn,
		input logic [ASID_W-1:0] asid
	);
		logic [TLB_ENTRIES-1:0] m;
		for (int k = 0; k < TLB_ENTRIES; k++) begin
			m[k] = e_q[k] && (ent_q[k].vppn == vppn) &&
				(ent_q[k].g || (ent_q[k].asid == asid));
		end
		return m;
	endfunction

	function automatic tlb_page_t pick_page(
		input logic [TLB_ENTRIES-1:0] m,
		input logic                   odd
	);
		tlb_page_t pg;
		pg = '0;
		for (int k = 0; k < TLB_ENTRIES; k++) begin
			if (m[k]) begin
				pg = odd ? ent_q[k].p1 : ent_q[k].p0;
			end
		end
		return pg;
	endfunction

	// only valid bits are cleared
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			e_q <= '0;
		end else if (we_i) begin
			e_q[widx_i] <= wentry_i.e;
		end
	end

	always_ff @(posedge clk) begin
		if (we_i) begin
			ent_q[widx_i] <= wentry_i;
		end
	end

	always_comb begin
		hits_if   = match_vec(lk_i.vppn, lk_i.asid);
		lk_i.hit  = |hits_if;
		lk_i.page = pick_page(hits_if, lk_i.odd);
	end

	always_comb begin
		hits_dt   = match_vec(lk_d.vppn, lk_d.asid);
		lk_d.hit  = |hits_dt;
		lk_d.page = pick_page(hits_dt, lk_d.odd);
	end

	a_fetch_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(hits_if));

	a_data_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(hits_dt));

endmodule

// ==== logic/mmu_csr.sv ====
`timescale 1ns/10ps

module mmu_csr import csr_pkg::*, mmu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 csr_we_i,
	input  logic [13:0]          csr_addr_i,
	input  logic [31:0]          csr_wdata_i,
	input  logic                 tlbwr_i,
	csr_view_if.owner            view_o,
	output logic                 tlb_we_o,
	output logic [TLB_IDX_W-1:0] tlb_widx_o,
	output tlb_entry_t           tlb_wentry_o
);

	crmd_t             crmd_q;
	logic [ASID_W-1:0] asid_q;
	dmw_t              dmw0_q;
	dmw_t              dmw1_q;
	logic [31:0]       tlbidx_q;
	logic [31:0]       tlbehi_q;
	tlbelo_t           tlbelo0_q;
	tlbelo_t           tlbelo1_q;
	tlb_entry_t        new_entry;

	function automatic tlb_page_t to_page(input tlbelo_t lo);
		tlb_page_t pg;
		pg.v   = lo.v;
		pg.d   = lo.d;
		pg.plv = lo.plv;
		pg.mat = lo.mat;
		pg.ppn = lo.ppn;
		return pg;
	endfunction

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			crmd_q    <= CRMD_RESET;
			asid_q    <= '0;
			dmw0_q    <= '0;
			dmw1_q    <= '0;
			tlbidx_q  <= '0;
			tlbehi_q  <= '0;
			tlbelo0_q <= '0;
			tlbelo1_q <= '0;
		end else if (csr_we_i) begin
			case (csr_addr_i)
				CSR_CRMD:    crmd_q    <= crmd_t'(csr_wdata_i & CRMD_WMASK);
				CSR_ASID:    asid_q    <= csr_wdata_i[ASID_W-1:0] & ASID_WMASK[ASID_W-1:0];
				CSR_DMW0:    dmw0_q    <= dmw_t'(csr_wdata_i & DMW_WMASK);
				CSR_DMW1:    dmw1_q    <= dmw_t'(csr_wdata_i & DMW_WMASK);
				CSR_TLBIDX:  tlbidx_q  <= csr_wdata_i & TLBIDX_WMASK;
				CSR_TLBEHI:  tlbehi_q  <= csr_wdata_i & TLBEHI_WMASK;
				CSR_TLBELO0: tlbelo0_q <= tlbelo_t'(csr_wdata_i & TLBELO_WMASK);
				CSR_TLBELO1: tlbelo1_q <= tlbelo_t'(csr_wdata_i & TLBELO_WMASK);
				default: ;
			endcase
		end
	end

	assign view_o.crmd = crmd_q;
	assign view_o.asid = asid_q;
	assign view_o.dmw0 = dmw0_q;
	assign view_o.dmw1 = dmw1_q;

	// entry image for tlbwr, global only if both halves say so
	always_comb begin
		new_entry.e    = ~tlbidx_q[TLBIDX_NE];
		new_entry.vppn = tlbehi_q[31:TLBEHI_VPPN_LSB];
		new_entry.ps   = PS_4K;
		new_entry.asid = asid_q;
		new_entry.g    = tlbelo0_q.g & tlbelo1_q.g;
		new_entry.p0   = to_page(tlbelo0_q);
		new_entry.p1   = to_page(tlbelo1_q);
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tlb_we_o <= 1'b0;
		end else begin
			tlb_we_o <= tlbwr_i;
		end
	end

	always_ff @(posedge clk) begin
		if (tlbwr_i) begin
			tlb_widx_o   <= tlbidx_q[TLB_IDX_W-1:0];
			tlb_wentry_o <= new_entry;
		end
	end

endmodule

// ==== logic/mmu_if.sv ====
`timescale 1ns/10ps

// translation state seen by the ports
interface csr_view_if import csr_pkg::*, mmu_pkg::*; ();

	crmd_t             crmd;
	logic [ASID_W-1:0] asid;
	dmw_t              dmw0;
	dmw_t              dmw1;

	modport owner (
		output crmd, asid, dmw0, dmw1
	);

	modport user (
		input crmd, asid, dmw0, dmw1
	);

endinterface

// combinational tlb search, one per port
interface tlb_lookup_if import mmu_pkg::*; ();

	logic [VPPN_W-1:0] vppn;
	logic              odd;
	logic [ASID_W-1:0] asid;
	logic              hit;
	tlb_page_t         page;

	modport requester (
		output vppn, odd, asid,
		input  hit, page
	);

	modport responder (
		input  vppn, odd, asid,
		output hit, page
	);

endinterface

// ==== logic/mmu_pkg.sv ====
package mmu_pkg;

	localparam int TLB_ENTRIES = 8;
	localparam int TLB_IDX_W   = 3;

	localparam int VPPN_W = 19;
	localparam int PPN_W  = 20;
	localparam int ASID_W = 10;

	// page size code of a 4 KB page
	localparam logic [5:0] PS_4K = 6'd12;

	// strongly ordered uncached
	localparam logic [1:0] MAT_SUC = 2'b00;

	// one half of an even/odd page pair
	typedef struct packed {
		logic             v;
		logic             d;
		logic [1:0]       plv;
		logic [1:0]       mat;
		logic [PPN_W-1:0] ppn;
	} tlb_page_t;

	typedef struct packed {
		logic              e;
		logic [VPPN_W-1:0] vppn;
		logic [5:0]        ps;
		logic [ASID_W-1:0] asid;
		logic              g;
		tlb_page_t         p0;
		tlb_page_t         p1;
	} tlb_entry_t;

	typedef enum logic [2:0] {
		EXC_NONE = 3'd0,
		EXC_TLBR = 3'd1,
		EXC_PIF  = 3'd2,
		EXC_PIL  = 3'd3,
		EXC_PIS  = 3'd4,
		EXC_PME  = 3'd5,
		EXC_PPI  = 3'd6
	} xlat_exc_t;

	typedef enum logic [1:0] {
		ACC_FETCH = 2'd0,
		ACC_LOAD  = 2'd1,
		ACC_STORE = 2'd2
	} acc_kind_t;

endpackage

// ==== logic/csr_pkg.sv ====
package csr_pkg;

	// csr numbers of the translation registers
	localparam logic [13:0] CSR_CRMD    = 14'h000;
	localparam logic [13:0] CSR_ASID    = 14'h018;
	localparam logic [13:0] CSR_TLBIDX  = 14'h010;
	localparam logic [13:0] CSR_TLBEHI  = 14'h011;
	localparam logic [13:0] CSR_TLBELO0 = 14'h012;
	localparam logic [13:0] CSR_TLBELO1 = 14'h013;
	localparam logic [13:0] CSR_DMW0    = 14'h180;
	localparam logic [13:0] CSR_DMW1    = 14'h181;

	// field positions
	localparam int TLBIDX_NE       = 31;
	localparam int TLBEHI_VPPN_LSB = 13;

	// writable bits per register
	localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
	localparam logic [31:0] ASID_WMASK   = 32'h0000_03ff;
	localparam logic [31:0] TLBIDX_WMASK = 32'hbf00_000f;
	localparam logic [31:0] TLBEHI_WMASK = 32'hffff_e000;
	localparam logic [31:0] TLBELO_WMASK = 32'h0fff_ff7f;
	localparam logic [31:0] DMW_WMASK    = 32'hee00_0039;

	typedef struct packed {
		logic [22:0] rsvd;
		logic [1:0]  datm;
		logic [1:0]  datf;
		logic        pg;
		logic        da;
		logic        ie;
		logic [1:0]  plv;
	} crmd_t;

	// direct address mode after reset
	localparam crmd_t CRMD_RESET = '{da: 1'b1, default: '0};

	typedef struct packed {
		logic [2:0]  vseg;
		logic        rsvd0;
		logic [2:0]  pseg;
		logic [18:0] rsvd1;
		logic [1:0]  mat;
		logic        plv3;
		logic [1:0]  rsvd2;
		logic        plv0;
	} dmw_t;

	typedef struct packed {
		logic [3:0]  rsvd0;
		logic [19:0] ppn;
		logic        rsvd1;
		logic        g;
		logic [1:0]  mat;
		logic [1:0]  plv;
		logic        d;
		logic        v;
	} tlbelo_t;

endpackage
